// ==== include/vldu_defs.svh ====
// Sizing macros for the vector load unit
// NR_LANES and RESULT_DEPTH are expected to be powers of two
// VREG_WORDS times 32 must fit in a VADDR_W bit word address

`ifndef VLDU_DEFS_SVH
`define VLDU_DEFS_SVH

// Number of VRF lanes, each one 64 bits wide
`define NR_LANES 4

// In-flight load instructions held by the unit
`define VINSN_DEPTH 4

// Entries in each per-lane result FIFO
`define RESULT_DEPTH 2

// Instruction IDs handed out by the sequencer
`define NR_VINSN 8

// Vector length width, in elements
`define VL_W 16

// Words of one vector register stored in a single lane
`define VREG_WORDS 8

// Word address width inside one lane of the VRF
`define VADDR_W 8

`endif

// ==== source/vldu_pkg.sv ====
// Shared types of the vector load unit
// Lane words are fixed at 64 bits, one byte enable per byte
// Sizes come from the defs header

package vldu_pkg;

  `include "vldu_defs.svh"

  // One lane word and its byte enables
  typedef logic [63:0] elen_t;
  typedef logic [7:0]  strb_t;

  // Instruction ID
  typedef logic [2:0] vid_t;

  // Word address within one lane
  typedef logic [`VADDR_W-1:0] vaddr_t;

  // Vector length in elements
  typedef logic [`VL_W-1:0] vlen_t;

  // Element width, log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vsew_e;

  // Load request from the sequencer
  typedef struct packed {
    vid_t       id;
    logic [4:0] vd;
    vlen_t      vl;
    vsew_e      vsew;
    // Set for an unmasked load
    logic       vm;
  } vld_req_t;

  // Write request towards one lane of the VRF
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_result_t;

  // Full read beat, one VRF word over all lanes
  typedef logic [`NR_LANES*64-1:0] beat_t;

  // Mask bytes for every lane, laid out like the lane bytes
  typedef logic [`NR_LANES*8-1:0] lane_strb_t;

  // One done bit per instruction ID
  typedef logic [`NR_VINSN-1:0] done_t;

endpackage

// ==== source/vldu_insn_queue.sv ====
// Instruction queue of the vector load unit
// Holds up to VINSN_DEPTH loads, an entry stays until its results commit
// Issue and commit heads move independently
// Done pulses are only expected while the matching head is valid

`timescale 1ns/10ps

`include "vldu_defs.svh"

module vldu_insn_queue (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Sequencer side
  input  vldu_pkg::vld_req_t req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  // Issue head, towards the word builder
  output vldu_pkg::vld_req_t issue_req_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  // Commit head, towards the commit tracker
  output vldu_pkg::vld_req_t commit_req_o,
  output logic               commit_valid_o,
  input  logic               commit_done_i
);

  import vldu_pkg::*;

  localparam int unsigned Depth = `VINSN_DEPTH;
  localparam int unsigned PtrW  = $clog2(Depth);
  localparam int unsigned CntW  = $clog2(Depth + 1);

  // Stored requests
  vld_req_t mem_q [Depth];

  // Slot written by the next accept, and the two read heads
  logic [PtrW-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting to issue, and waiting to commit
  logic [CntW-1:0] issue_cnt_q, issue_cnt_d;
  logic [CntW-1:0] commit_cnt_q, commit_cnt_d;

  logic accept;

  // Circular increment
  function automatic logic [PtrW-1:0] next_pnt(input logic [PtrW-1:0] pnt);
    return (pnt == PtrW'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Entries are freed only on commit, so the commit count decides fullness
  assign req_ready_o = (commit_cnt_q != CntW'(Depth));
  assign accept      = req_valid_i && req_ready_o;

  assign issue_req_o    = mem_q[issue_pnt_q];
  assign issue_valid_o  = (issue_cnt_q != '0);
  assign commit_req_o   = mem_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

  // An accept and a done in one cycle cancel out
  always_comb begin
    issue_cnt_d = issue_cnt_q;
    if (accept && !issue_done_i) begin
      issue_cnt_d = issue_cnt_q + 1'b1;
    end else if (!accept && issue_done_i) begin
      issue_cnt_d = issue_cnt_q - 1'b1;
    end

    commit_cnt_d = commit_cnt_q;
    if (accept && !commit_done_i) begin
      commit_cnt_d = commit_cnt_q + 1'b1;
    end else if (!accept && commit_done_i) begin
      commit_cnt_d = commit_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      issue_cnt_q  <= issue_cnt_d;
      commit_cnt_q <= commit_cnt_d;
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      // Heads move the cycle after their done pulse
      if (issue_done_i) begin
        issue_pnt_q <= next_pnt(issue_pnt_q);
      end
      if (commit_done_i) begin
        commit_pnt_q <= next_pnt(commit_pnt_q);
      end
    end
  end

endmodule

// ==== source/vldu_word_builder.sv ====
// Turns read beats into shuffled, masked words for every lane
// Each beat is one full aligned VRF word, NR_LANES times 8 bytes
// An instruction gets exactly the beats it needs, vl must be nonzero
// Pushes go to all lane FIFOs at once, so any full lane stalls the beat

`timescale 1ns/10ps

`include "vldu_defs.svh"

module vldu_word_builder (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Issue head of the instruction queue
  input  vldu_pkg::vld_req_t                     issue_req_i,
  input  logic                                   issue_valid_i,
  output logic                                   issue_done_o,
  // Read data
  input  vldu_pkg::beat_t                        r_data_i,
  input  logic                                   r_valid_i,
  output logic                                   r_ready_o,
  // Mask operands
  input  vldu_pkg::lane_strb_t                   mask_i,
  input  logic                                   mask_valid_i,
  output logic                                   mask_ready_o,
  // Lane FIFOs
  input  logic                   [`NR_LANES-1:0] lane_full_i,
  output logic                                   push_o,
  output vldu_pkg::lane_result_t [`NR_LANES-1:0] word_o
);

  import vldu_pkg::*;

  localparam int unsigned WordBytes = `NR_LANES * 8;

  // Set once the current head has had its first word built
  logic   loaded_q;
  // Elements still to be written, and the word index inside the register
  vlen_t  rem_q, rem_eff;
  vaddr_t widx_q, widx_eff;

  logic [1:0] sew;
  vlen_t      elems_per_word;
  logic       consume;
  logic       last_word;

  assign sew = issue_req_i.vsew;

  // A fresh head starts from its own vl and word zero
  assign rem_eff  = loaded_q ? rem_q : issue_req_i.vl;
  assign widx_eff = loaded_q ? widx_q : '0;

  // Elements per full VRF word, 32 for EW8 down to 4 for EW64
  assign elems_per_word = vlen_t'(`NR_LANES) << (2'd3 - sew);
  assign last_word      = (rem_eff <= elems_per_word);

  // Masked loads also wait for their mask bytes
  assign r_ready_o = issue_valid_i && (issue_req_i.vm || mask_valid_i) && !(|lane_full_i);
  assign consume   = r_valid_i && r_ready_o;

  assign push_o       = consume;
  assign mask_ready_o = consume && !issue_req_i.vm;
  assign issue_done_o = consume && last_word;

  // Byte shuffle
  always_comb begin
    int unsigned elem;
    int unsigned lane;
    int unsigned lbyte;

    for (int l = 0; l < `NR_LANES; l++) begin
      word_o[l].id    = issue_req_i.id;
      word_o[l].addr  = vaddr_t'(issue_req_i.vd * `VREG_WORDS) + widx_eff;
      word_o[l].wdata = '0;
      word_o[l].be    = '0;
    end

    for (int b = 0; b < WordBytes; b++) begin
      // Element of this byte, counted from the start of the beat
      elem  = b >> sew;
      // Consecutive elements rotate over the lanes
      lane  = elem % `NR_LANES;
      // Slot inside the lane, keeping the byte offset within the element
      lbyte = ((elem / `NR_LANES) << sew) + (b & ((1 << sew) - 1));
      word_o[lane].wdata[8*lbyte +: 8] = r_data_i[8*b +: 8];
      // Tail elements past vl and masked-off elements stay disabled
      word_o[lane].be[lbyte] = (elem < rem_eff) &&
                               (issue_req_i.vm || mask_i[lane*8 + lbyte]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      loaded_q <= 1'b0;
      rem_q    <= '0;
      widx_q   <= '0;
    end else if (consume) begin
      if (last_word) begin
        // Next head is picked up fresh
        loaded_q <= 1'b0;
      end else begin
        loaded_q <= 1'b1;
        rem_q    <= rem_eff - elems_per_word;
        widx_q   <= widx_eff + 1'b1;
      end
    end
  end

endmodule

// ==== source/vldu_lane_queue.sv ====
// Result FIFO of one lane, RESULT_DEPTH entries
// The head is offered to the VRF until granted
// A push while full is never issued, the word builder stalls first

`timescale 1ns/10ps

`include "vldu_defs.svh"

module vldu_lane_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Word builder side
  input  logic                   push_i,
  input  vldu_pkg::lane_result_t word_i,
  output logic                   full_o,
  // VRF write port of this lane
  output logic                   result_req_o,
  output vldu_pkg::lane_result_t result_o,
  input  logic                   result_gnt_i,
  // Entry retired, towards the commit tracker
  output logic                   pop_o
);

  import vldu_pkg::*;

  localparam int unsigned Depth = `RESULT_DEPTH;
  localparam int unsigned PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW  = $clog2(Depth + 1);

  lane_result_t mem_q [Depth];

  logic [PtrW-1:0] wr_pnt_q, rd_pnt_q;
  logic [CntW-1:0] cnt_q;

  function automatic logic [PtrW-1:0] next_pnt(input logic [PtrW-1:0] pnt);
    return (pnt == PtrW'(Depth - 1)) ? '0 : pnt + 1'b1;
  endfunction

  assign full_o       = (cnt_q == CntW'(Depth));
  assign result_req_o = (cnt_q != '0);
  assign result_o     = mem_q[rd_pnt_q];

  // Grant is a strobe, only counted against a pending request
  assign pop_o = result_gnt_i && result_req_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_pnt_q] <= word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= next_pnt(wr_pnt_q);
      end
      if (pop_o) begin
        rd_pnt_q <= next_pnt(rd_pnt_q);
      end
      cnt_q <= cnt_q + CntW'(push_i) - CntW'(pop_o);
    end
  end

endmodule

// ==== source/vldu_commit_tracker.sv ====
// Counts lane writes and reports finished loads
// A VRF word counts as committed once every lane has written its part
// Lanes may run up to RESULT_DEPTH words apart
// vinsn_done_o is a registered one-cycle pulse

`timescale 1ns/10ps

`include "vldu_defs.svh"

module vldu_commit_tracker (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // Commit head of the instruction queue
  input  vldu_pkg::vld_req_t             commit_req_i,
  input  logic                           commit_valid_i,
  output logic                           commit_done_o,
  // One pop pulse per lane FIFO
  input  logic           [`NR_LANES-1:0] pop_i,
  output vldu_pkg::done_t                vinsn_done_o
);

  import vldu_pkg::*;

  localparam int unsigned WordBytes = `NR_LANES * 8;
  localparam int unsigned PendW     = $clog2(`RESULT_DEPTH + 1) + 1;
  localparam int unsigned CntW      = `VL_W + 4;

  // Words a lane has written ahead of the slowest lane
  logic [`NR_LANES-1:0][PendW-1:0] pend_q, pend_d, pend_eff;
  logic                            commit_word;

  logic [1:0]      sew;
  logic [CntW-1:0] insn_bytes, insn_words;
  logic [CntW-1:0] word_idx_q;
  done_t           done_d;

  assign sew = commit_req_i.vsew;

  // Ceiling of the instruction bytes over one VRF word
  assign insn_bytes = CntW'(commit_req_i.vl) << sew;
  assign insn_words = (insn_bytes + CntW'(WordBytes - 1)) / CntW'(WordBytes);

  always_comb begin
    commit_word = 1'b1;
    for (int l = 0; l < `NR_LANES; l++) begin
      pend_eff[l] = pend_q[l] + PendW'(pop_i[l]);
      if (pend_eff[l] == '0) begin
        commit_word = 1'b0;
      end
    end
    // A full word retires from every lane count together
    for (int l = 0; l < `NR_LANES; l++) begin
      pend_d[l] = pend_eff[l] - PendW'(commit_word);
    end
  end

  assign commit_done_o = commit_valid_i && commit_word && (word_idx_q == insn_words - 1'b1);

  always_comb begin
    done_d = '0;
    if (commit_done_o) begin
      done_d[commit_req_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q       <= '0;
      word_idx_q   <= '0;
      vinsn_done_o <= '0;
    end else begin
      pend_q       <= pend_d;
      vinsn_done_o <= done_d;
      if (commit_done_o) begin
        word_idx_q <= '0;
      end else if (commit_word) begin
        word_idx_q <= word_idx_q + 1'b1;
      end
    end
  end

endmodule

// ==== source/vldu_top.sv ====
// Vector load unit for a lane-partitioned VRF
// Read beats are full aligned VRF words, one set of result ports per lane
// Grants are strobes and need no ready

`timescale 1ns/10ps

`include "vldu_defs.svh"

module vldu_top (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  // Sequencer
  input  vldu_pkg::vld_req_t                     req_i,
  input  logic                                   req_valid_i,
  output logic                                   req_ready_o,
  // Memory read data
  input  vldu_pkg::beat_t                        r_data_i,
  input  logic                                   r_valid_i,
  output logic                                   r_ready_o,
  // Mask unit
  input  vldu_pkg::lane_strb_t                   mask_i,
  input  logic                                   mask_valid_i,
  output logic                                   mask_ready_o,
  // Lanes
  output logic                   [`NR_LANES-1:0] result_req_o,
  output vldu_pkg::lane_result_t [`NR_LANES-1:0] result_o,
  input  logic                   [`NR_LANES-1:0] result_gnt_i,
  // Finished instructions
  output vldu_pkg::done_t                        vinsn_done_o
);

  import vldu_pkg::*;

  vld_req_t issue_req, commit_req;
  logic     issue_valid, issue_done;
  logic     commit_valid, commit_done;

  logic                             push;
  lane_result_t [`NR_LANES-1:0]     word;
  logic         [`NR_LANES-1:0]     lane_full;
  logic         [`NR_LANES-1:0]     lane_pop;

  vldu_insn_queue insn_queue_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .issue_req_o    (issue_req),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .commit_req_o   (commit_req),
    .commit_valid_o (commit_valid),
    .commit_done_i  (commit_done)
  );

  vldu_word_builder word_builder_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_req_i   (issue_req),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .r_data_i      (r_data_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .mask_i        (mask_i),
    .mask_valid_i  (mask_valid_i),
    .mask_ready_o  (mask_ready_o),
    .lane_full_i   (lane_full),
    .push_o        (push),
    .word_o        (word)
  );

  // One result FIFO per lane, all fed by the same push
  for (genvar l = 0; l < `NR_LANES; l++) begin : gen_lane
    vldu_lane_queue lane_queue_i (
      .clk_i        (clk_i),
      .rst_ni       (rst_ni),
      .push_i       (push),
      .word_i       (word[l]),
      .full_o       (lane_full[l]),
      .result_req_o (result_req_o[l]),
      .result_o     (result_o[l]),
      .result_gnt_i (result_gnt_i[l]),
      .pop_o        (lane_pop[l])
    );
  end

  vldu_commit_tracker commit_tracker_i (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_req_i   (commit_req),
    .commit_valid_i (commit_valid),
    .commit_done_o  (commit_done),
    .pop_i          (lane_pop),
    .vinsn_done_o   (vinsn_done_o)
  );

endmodule

// ==== test/vldu_tb.sv ====
// Directed testbench for the vector load unit
// Beats are full aligned VRF words, every load gets exactly its beats
// Outputs are sampled on the falling edge, inputs change 1 ns after the rising edge
// Expected lane words come from the shuffle, enable and address rules

`timescale 1ns/10ps

`include "vldu_defs.svh"

module vldu_tb;

  import vldu_pkg::*;

  localparam int WordBytes      = `NR_LANES * 8;
  // Beats over all tests are 2 + 2 + 3 + 3 + 5 * 2
  localparam int TotalBeats     = 20;
  localparam int WatchdogCycles = TotalBeats * 50;
  localparam int DoneTimeout    = 200;

  logic                           clk_i;
  logic                           rst_ni;
  vld_req_t                       req_i;
  logic                           req_valid_i;
  logic                           req_ready_o;
  beat_t                          r_data_i;
  logic                           r_valid_i;
  logic                           r_ready_o;
  lane_strb_t                     mask_i;
  logic                           mask_valid_i;
  logic                           mask_ready_o;
  logic         [`NR_LANES-1:0]   result_req_o;
  lane_result_t [`NR_LANES-1:0]   result_o;
  logic         [`NR_LANES-1:0]   result_gnt_i;
  done_t                          vinsn_done_o;

  // Expected lane words in write order per lane
  lane_result_t exp_q [`NR_LANES][$];
  // Loads in the order their done pulses must come
  vid_t         done_order_q [$];
  // Lane words still to be granted per instruction ID
  int           pend_words [`NR_VINSN];

  int  errors;
  int  checks;
  int  done_seen;
  int  mask_seen;
  // Random grant stalls on all lanes
  bit  stall_en;

  vldu_top vldu_top_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .r_data_i     (r_data_i),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .mask_i       (mask_i),
    .mask_valid_i (mask_valid_i),
    .mask_ready_o (mask_ready_o),
    .result_req_o (result_req_o),
    .result_o     (result_o),
    .result_gnt_i (result_gnt_i),
    .vinsn_done_o (vinsn_done_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Grants stay high unless random stalls are on
  initial begin
    logic [31:0] rnd;
    forever begin
      @(posedge clk_i);
      #1;
      rnd = $urandom;
      result_gnt_i = stall_en ? rnd[`NR_LANES-1:0] : {`NR_LANES{1'b1}};
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
    $display("Done: errors found");
    $finish;
  end

  task automatic check_result(input string name, input lane_result_t got,
                              input lane_result_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_done(input done_t got, input done_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] vinsn_done_o: got %h, expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  function automatic int elem_bytes(input vsew_e sew);
    case (sew)
      EW8:     return 1;
      EW16:    return 2;
      EW32:    return 4;
      default: return 8;
    endcase
  endfunction

  // VRF words and beats that one load needs
  function automatic int load_words(input vld_req_t req);
    return (int'(req.vl) * elem_bytes(req.vsew) + WordBytes - 1) / WordBytes;
  endfunction

  function automatic vld_req_t make_req(input int id, input int vd, input int vl,
                                        input vsew_e sew, input bit vm);
    vld_req_t req;
    req.id   = vid_t'(id);
    req.vd   = 5'(vd);
    req.vl   = vlen_t'(vl);
    req.vsew = sew;
    req.vm   = vm;
    return req;
  endfunction

  function automatic beat_t random_beat();
    beat_t data;
    for (int k = 0; k < WordBytes / 4; k++) begin
      data[32*k +: 32] = $urandom;
    end
    return data;
  endfunction

  // Reference lane word for one beat
  function automatic lane_result_t model_word(input vld_req_t req, input beat_t data,
                                              input lane_strb_t mask, input int rem,
                                              input int widx, input int lane);
    lane_result_t res;
    int eb;
    int e;
    int slot;
    res       = '0;
    eb        = elem_bytes(req.vsew);
    res.id    = req.id;
    res.addr  = vaddr_t'(int'(req.vd) * `VREG_WORDS + widx);
    for (int b = 0; b < WordBytes; b++) begin
      e = b / eb;
      if (e % `NR_LANES == lane) begin
        slot = (e / `NR_LANES) * eb + b % eb;
        res.wdata[8*slot +: 8] = data[8*b +: 8];
        res.be[slot] = (e < rem) && (req.vm || mask[lane*8 + slot]);
      end
    end
    return res;
  endfunction

  // Lane writes and done pulses
  always @(negedge clk_i) begin : monitor
    lane_result_t exp;
    vid_t         id;
    if (rst_ni) begin
      for (int l = 0; l < `NR_LANES; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          if (exp_q[l].size() == 0) begin
            errors++;
            $display("Lane %0d wrote a word that no load expected at %0t", l, $time);
          end else begin
            exp = exp_q[l].pop_front();
            check_result($sformatf("result_o[%0d]", l), result_o[l], exp);
            pend_words[exp.id]--;
          end
        end
      end
      if (mask_ready_o) begin
        mask_seen++;
      end
      if (vinsn_done_o != '0) begin
        done_seen++;
        if (done_order_q.size() == 0) begin
          errors++;
          $display("Unexpected completion pulse %h at %0t", vinsn_done_o, $time);
        end else begin
          id = done_order_q.pop_front();
          check_done(vinsn_done_o, done_t'(1) << id);
          // All lanes must have had their last grant already
          if (pend_words[id] != 0) begin
            errors++;
            $display("Load %0d finished with %0d lane words not yet written",
                     id, pend_words[id]);
          end
        end
      end
    end
  end

  task automatic expect_load(input vld_req_t req);
    done_order_q.push_back(req.id);
    pend_words[req.id] += load_words(req) * `NR_LANES;
  endtask

  // Entered and left 1 ns after a rising edge
  task automatic send_req(input vld_req_t req, output int done_before);
    req_i       = req;
    req_valid_i = 1'b1;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    #1;
    req_valid_i = 1'b0;
    done_before = done_seen;
  endtask

  task automatic load_beats(input vld_req_t req);
    int         epw;
    beat_t      data;
    lane_strb_t mask;
    epw = WordBytes / elem_bytes(req.vsew);
    for (int i = 0; i < load_words(req); i++) begin
      data = random_beat();
      mask = $urandom;
      for (int l = 0; l < `NR_LANES; l++) begin
        exp_q[l].push_back(model_word(req, data, mask, int'(req.vl) - i * epw, i, l));
      end
      r_data_i     = data;
      mask_i       = mask;
      r_valid_i    = 1'b1;
      mask_valid_i = !req.vm;
      do @(negedge clk_i); while (!r_ready_o);
      @(posedge clk_i);
      #1;
    end
    r_valid_i    = 1'b0;
    mask_valid_i = 1'b0;
  endtask

  task automatic wait_done();
    int cnt;
    cnt = 0;
    while (done_order_q.size() != 0 && cnt < DoneTimeout) begin
      @(posedge clk_i);
      #1;
      cnt++;
    end
    if (done_order_q.size() != 0) begin
      errors++;
      $display("Timed out after %0d cycles waiting for a load to finish", DoneTimeout);
    end
    for (int l = 0; l < `NR_LANES; l++) begin
      if (exp_q[l].size() != 0) begin
        errors++;
        $display("Lane %0d never wrote %0d expected words", l, exp_q[l].size());
      end
    end
  endtask

  task automatic run_single_load(input vld_req_t req);
    int unused;
    expect_load(req);
    send_req(req, unused);
    load_beats(req);
    wait_done();
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    $display("Test %0d %s finished with %0d errors", num, name, errors - err_before);
  endtask

  task automatic reset_dut();
    rst_ni = 1'b0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag("req_ready_o", req_ready_o, 1'b1);
    check_flag("r_ready_o", r_ready_o, 1'b0);
    check_flag("mask_ready_o", mask_ready_o, 1'b0);
    check_flag("result_req_o", |result_req_o, 1'b0);
    check_done(vinsn_done_o, '0);
    @(posedge clk_i);
    #1;
  endtask

  // Five loads against a four deep queue with the read data held back
  task automatic queue_full_test();
    vld_req_t reqs [5];
    int       unused;
    int       done0;
    int       done_at_fifth;
    done0 = done_seen;
    for (int i = 0; i < 5; i++) begin
      reqs[i] = make_req(i + 1, 10 + i, 16, EW32, 1'b1);
    end
    for (int i = 0; i < 4; i++) begin
      expect_load(reqs[i]);
      send_req(reqs[i], unused);
    end
    @(negedge clk_i);
    check_flag("req_ready_o", req_ready_o, 1'b0);
    @(posedge clk_i);
    #1;
    expect_load(reqs[4]);
    fork
      send_req(reqs[4], done_at_fifth);
      begin
        for (int i = 0; i < 4; i++) begin
          load_beats(reqs[i]);
        end
      end
    join
    if (done_at_fifth - done0 < 1) begin
      errors++;
      $display("Fifth load was accepted before any load had finished");
    end
    load_beats(reqs[4]);
    wait_done();
  endtask

  initial begin
    int       err0;
    int       masks0;
    vld_req_t masked_req;
    void'($urandom(54));
    rst_ni       = 1'b0;
    req_i        = '0;
    req_valid_i  = 1'b0;
    r_data_i     = '0;
    r_valid_i    = 1'b0;
    mask_i       = '0;
    mask_valid_i = 1'b0;
    result_gnt_i = '0;
    stall_en     = 1'b0;
    errors       = 0;
    checks       = 0;
    done_seen    = 0;
    mask_seen    = 0;
    for (int i = 0; i < `NR_VINSN; i++) begin
      pend_words[i] = 0;
    end

    reset_dut();

    err0 = errors;
    run_single_load(make_req(2, 3, 8, EW64, 1'b1));
    report_test(1, "EW64 unmasked", err0);

    err0 = errors;
    run_single_load(make_req(3, 5, 40, EW8, 1'b1));
    report_test(2, "EW8 shuffle with tail", err0);

    err0       = errors;
    masks0     = mask_seen;
    masked_req = make_req(4, 7, 40, EW16, 1'b0);
    run_single_load(masked_req);
    if (mask_seen - masks0 != load_words(masked_req)) begin
      errors++;
      $display("mask_ready_o pulsed %0d times for %0d beats",
               mask_seen - masks0, load_words(masked_req));
    end
    report_test(3, "EW16 masked", err0);

    err0     = errors;
    stall_en = 1'b1;
    run_single_load(make_req(5, 9, 24, EW32, 1'b1));
    stall_en = 1'b0;
    report_test(4, "random grant stalls", err0);

    err0 = errors;
    queue_full_test();
    report_test(5, "full instruction queue", err0);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
source/vldu_pkg.sv
source/vldu_insn_queue.sv
source/vldu_word_builder.sv
source/vldu_lane_queue.sv
source/vldu_commit_tracker.sv
source/vldu_top.sv
test/vldu_tb.sv
